// ==== Makefile ====
VERILATOR  := verilator
TOP        := huff_tb
LINT_TOP   := huff_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/char_histogram.sv ====
`timescale 1ns/1ps

module char_histogram
  import huff_pkg::*;
#(
  parameter logic [31:0] base_addr = 32'h0000_0000
) (
  input  logic               hwclk,
  input  logic               reset,
  input  huff_phase_t        phase_i,
  input  logic               char_valid_i,
  input  logic [char_w-1:0]  char_i,
  output logic               char_ready_o,
  output logic               clear_done_o,
  output logic               count_done_o,
  output logic [count_w-1:0] total_o,
  sram_req_if.client         bus
);

  typedef enum logic [2:0] {
    st_clr_wr,
    st_clr_gap,
    st_idle,
    st_read,
    st_rd_gap,
    st_write,
    st_finished
  } state_t;

  state_t             state;
  // clear index during the wipe, latched character afterwards
  logic [char_w-1:0]  entry_q;
  logic [count_w-1:0] cnt_q;
  logic               accept;

  assign char_ready_o = (phase_i == phase_count) && (state == st_idle);
  assign accept       = char_valid_i && char_ready_o;

  // gap states keep req low for a cycle after each done
  assign bus.req   = (state == st_clr_wr) || (state == st_read) || (state == st_write);
  assign bus.we    = (state == st_clr_wr) || (state == st_write);
  assign bus.addr  = base_addr + (32'(entry_q) << 2);
  assign bus.wdata = (state == st_write) ? cnt_q : '0;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state        <= st_clr_wr;
      entry_q      <= '0;
      total_o      <= '0;
      clear_done_o <= 1'b0;
      count_done_o <= 1'b0;
    end else begin
      clear_done_o <= 1'b0;
      count_done_o <= 1'b0;
      case (state)
        st_clr_wr: begin
          if (bus.done) begin
            if (entry_q == char_w'(alphabet_n - 1)) begin
              clear_done_o <= 1'b1;
              state        <= st_idle;
            end else begin
              state <= st_clr_gap;
            end
          end
        end
        st_clr_gap: begin
          entry_q <= entry_q + 1'b1;
          state   <= st_clr_wr;
        end
        st_idle: begin
          if (accept) begin
            if (char_i == eof_char) begin
              count_done_o <= 1'b1;
              state        <= st_finished;
            end else begin
              entry_q <= char_i;
              state   <= st_read;
            end
          end
        end
        st_read: begin
          if (bus.done) state <= st_rd_gap;
        end
        st_rd_gap: state <= st_write;
        st_write: begin
          if (bus.done) begin
            total_o <= total_o + 1'b1;
            state   <= st_idle;
          end
        end
        default: ;
      endcase
    end
  end

  // incremented count, written back on the next request
  always_ff @(posedge hwclk) begin
    if (state == st_read && bus.done) begin
      cnt_q <= bus.rdata + 1'b1;
    end
  end

endmodule

// ==== logic/huff_pkg.sv ====
package huff_pkg;

  // character and table geometry
  localparam int char_w     = 7;
  localparam int alphabet_n = 128;

  // one table count fills one SRAM word
  localparam int count_w = 32;

  // end-of-file code, ends the count and is never counted
  localparam logic [char_w-1:0] eof_char = 7'h1A;

  // subsystem phases, in the order they run after reset
  typedef enum logic [1:0] {
    phase_clear,
    phase_count,
    phase_scan,
    phase_done
  } huff_phase_t;

endpackage

// ==== logic/huff_sequencer.sv ====
`timescale 1ns/1ps

module huff_sequencer
  import huff_pkg::*;
(
  input  logic        hwclk,
  input  logic        reset,
  input  logic        clear_done_i,
  input  logic        count_done_i,
  input  logic        scan_done_i,
  output huff_phase_t phase_o,
  output logic        done_o,
  sram_req_if.manager hist_bus,
  sram_req_if.manager scan_bus,
  sram_req_if.client  mgr_bus
);

  huff_phase_t phase_q;
  logic        hist_own;
  logic        scan_own;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      phase_q <= phase_clear;
    end else begin
      case (phase_q)
        phase_clear: if (clear_done_i) phase_q <= phase_count;
        phase_count: if (count_done_i) phase_q <= phase_scan;
        phase_scan:  if (scan_done_i)  phase_q <= phase_done;
        default: ;
      endcase
    end
  end

  assign phase_o = phase_q;
  assign done_o  = (phase_q == phase_done);

  // bus ownership follows the phase
  assign hist_own = (phase_q == phase_clear) || (phase_q == phase_count);
  assign scan_own = (phase_q == phase_scan);

  assign mgr_bus.req   = (hist_own && hist_bus.req) || (scan_own && scan_bus.req);
  assign mgr_bus.we    = hist_own ? hist_bus.we    : scan_bus.we;
  assign mgr_bus.addr  = hist_own ? hist_bus.addr  : scan_bus.addr;
  assign mgr_bus.wdata = hist_own ? hist_bus.wdata : scan_bus.wdata;

  // read data can fan out, done only to the owner
  assign hist_bus.rdata = mgr_bus.rdata;
  assign scan_bus.rdata = mgr_bus.rdata;
  assign hist_bus.done  = hist_own && mgr_bus.done;
  assign scan_bus.done  = scan_own && mgr_bus.done;

endmodule

// ==== logic/huff_top.sv ====
`timescale 1ns/1ps

module huff_top
  import huff_pkg::*;
#(
  parameter logic [31:0] base_addr = 32'h0000_0000
) (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               char_valid_i,
  input  logic [char_w-1:0]  char_i,
  output logic               char_ready_o,
  output logic               done_o,
  output logic [count_w-1:0] total_o,
  output logic [char_w-1:0]  least1_char_o,
  output logic [count_w-1:0] least1_count_o,
  output logic [char_w-1:0]  least2_char_o,
  output logic [count_w-1:0] least2_count_o,
  output logic               wbs_stb_o,
  output logic               wbs_cyc_o,
  output logic               wbs_we_o,
  output logic [3:0]         wbs_sel_o,
  output logic [31:0]        wbs_adr_o,
  output logic [31:0]        wbs_dat_o,
  input  logic               wbs_ack_i,
  input  logic [31:0]        wbs_dat_i
);

  huff_phase_t phase;
  logic        clear_done;
  logic        count_done;
  logic        scan_done;

  sram_req_if hist_bus ();
  sram_req_if scan_bus ();
  sram_req_if mgr_bus ();

  char_histogram #(
    .base_addr(base_addr)
  ) u_hist (
    .hwclk       (hwclk),
    .reset       (reset),
    .phase_i     (phase),
    .char_valid_i(char_valid_i),
    .char_i      (char_i),
    .char_ready_o(char_ready_o),
    .clear_done_o(clear_done),
    .count_done_o(count_done),
    .total_o     (total_o),
    .bus         (hist_bus.client)
  );

  least_value_finder #(
    .base_addr(base_addr)
  ) u_flv (
    .hwclk         (hwclk),
    .reset         (reset),
    .phase_i       (phase),
    .scan_done_o   (scan_done),
    .least1_char_o (least1_char_o),
    .least2_char_o (least2_char_o),
    .least1_count_o(least1_count_o),
    .least2_count_o(least2_count_o),
    .bus           (scan_bus.client)
  );

  huff_sequencer u_seq (
    .hwclk       (hwclk),
    .reset       (reset),
    .clear_done_i(clear_done),
    .count_done_i(count_done),
    .scan_done_i (scan_done),
    .phase_o     (phase),
    .done_o      (done_o),
    .hist_bus    (hist_bus.manager),
    .scan_bus    (scan_bus.manager),
    .mgr_bus     (mgr_bus.client)
  );

  wishbone_manager u_wb (
    .hwclk    (hwclk),
    .reset    (reset),
    .bus      (mgr_bus.manager),
    .wbs_stb_o(wbs_stb_o),
    .wbs_cyc_o(wbs_cyc_o),
    .wbs_we_o (wbs_we_o),
    .wbs_sel_o(wbs_sel_o),
    .wbs_adr_o(wbs_adr_o),
    .wbs_dat_o(wbs_dat_o),
    .wbs_ack_i(wbs_ack_i),
    .wbs_dat_i(wbs_dat_i)
  );

endmodule

// ==== logic/least_value_finder.sv ====
`timescale 1ns/1ps

module least_value_finder
  import huff_pkg::*;
#(
  parameter logic [31:0] base_addr = 32'h0000_0000
) (
  input  logic               hwclk,
  input  logic               reset,
  input  huff_phase_t        phase_i,
  output logic               scan_done_o,
  output logic [char_w-1:0]  least1_char_o,
  output logic [char_w-1:0]  least2_char_o,
  output logic [count_w-1:0] least1_count_o,
  output logic [count_w-1:0] least2_count_o,
  sram_req_if.client         bus
);

  typedef enum logic [1:0] {
    st_wait,
    st_read,
    st_gap,
    st_finished
  } state_t;

  state_t            state;
  logic [char_w-1:0] idx_q;
  // a result slot holds nothing until its first candidate
  logic              l1_valid;
  logic              l2_valid;
  logic              take_first;
  logic              take_second;

  assign bus.req   = (state == st_read);
  assign bus.we    = 1'b0;
  assign bus.addr  = base_addr + (32'(idx_q) << 2);
  assign bus.wdata = '0;

  // strict compares, so a tie keeps the lower code
  assign take_first  = (bus.rdata != '0) && (!l1_valid || bus.rdata < least1_count_o);
  assign take_second = (bus.rdata != '0) && !take_first &&
                       (!l2_valid || bus.rdata < least2_count_o);

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state          <= st_wait;
      idx_q          <= '0;
      scan_done_o    <= 1'b0;
      l1_valid       <= 1'b0;
      l2_valid       <= 1'b0;
      least1_char_o  <= '0;
      least2_char_o  <= '0;
      least1_count_o <= '0;
      least2_count_o <= '0;
    end else begin
      scan_done_o <= 1'b0;
      case (state)
        st_wait: begin
          if (phase_i == phase_scan) state <= st_read;
        end
        st_read: begin
          if (bus.done) begin
            if (take_first) begin
              // old first result slides down
              least2_char_o  <= least1_char_o;
              least2_count_o <= least1_count_o;
              l2_valid       <= l1_valid;
              least1_char_o  <= idx_q;
              least1_count_o <= bus.rdata;
              l1_valid       <= 1'b1;
            end else if (take_second) begin
              least2_char_o  <= idx_q;
              least2_count_o <= bus.rdata;
              l2_valid       <= 1'b1;
            end
            if (idx_q == char_w'(alphabet_n - 1)) begin
              scan_done_o <= 1'b1;
              state       <= st_finished;
            end else begin
              state <= st_gap;
            end
          end
        end
        st_gap: begin
          idx_q <= idx_q + 1'b1;
          state <= st_read;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== logic/sram_req_if.sv ====
`timescale 1ns/1ps

// single-word SRAM request channel
interface sram_req_if;

  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        done;

  // requester side
  modport client (
    output req, we, addr, wdata,
    input  rdata, done
  );

  // servicing side
  modport manager (
    input  req, we, addr, wdata,
    output rdata, done
  );

endinterface

// ==== logic/wishbone_manager.sv ====
`timescale 1ns/1ps

module wishbone_manager (
  input  logic        hwclk,
  input  logic        reset,
  sram_req_if.manager bus,
  output logic        wbs_stb_o,
  output logic        wbs_cyc_o,
  output logic        wbs_we_o,
  output logic [3:0]  wbs_sel_o,
  output logic [31:0] wbs_adr_o,
  output logic [31:0] wbs_dat_o,
  input  logic        wbs_ack_i,
  input  logic [31:0] wbs_dat_i
);

  typedef enum logic {
    st_idle,
    st_active
  } state_t;

  state_t      state;
  logic        done_q;
  logic [31:0] rdata_q;
  logic        start;
  logic        finish;

  // full-word transfers only
  assign wbs_sel_o = 4'hf;

  assign bus.done  = done_q;
  assign bus.rdata = rdata_q;

  // req is still high in the done cycle, so ignore it there
  assign start  = (state == st_idle) && bus.req && !done_q;
  assign finish = (state == st_active) && wbs_ack_i;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      wbs_stb_o <= 1'b0;
      wbs_cyc_o <= 1'b0;
      wbs_we_o  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        wbs_stb_o <= 1'b1;
        wbs_cyc_o <= 1'b1;
        wbs_we_o  <= bus.we;
        state     <= st_active;
      end else if (finish) begin
        wbs_stb_o <= 1'b0;
        wbs_cyc_o <= 1'b0;
        wbs_we_o  <= 1'b0;
        done_q    <= 1'b1;
        state     <= st_idle;
      end
    end
  end

  // address and data held for the whole cycle
  always_ff @(posedge hwclk) begin
    if (start) begin
      wbs_adr_o <= bus.addr;
      wbs_dat_o <= bus.wdata;
    end
    if (finish) begin
      rdata_q <= wbs_dat_i;
    end
  end

endmodule

// ==== tb.f ====
logic/huff_pkg.sv
logic/sram_req_if.sv
logic/wishbone_manager.sv
logic/char_histogram.sv
logic/least_value_finder.sv
logic/huff_sequencer.sv
logic/huff_top.sv
tests/huff_checker.sv
tests/huff_tb.sv

// ==== tests/huff_checker.sv ====
`timescale 1ns/1ps

module huff_checker (
  input logic        hwclk,
  input logic        reset,
  input logic        wb_stb_i,
  input logic        wb_cyc_i,
  input logic [31:0] wb_adr_i,
  input logic        wb_ack_i,
  input logic        char_ready_i,
  input logic        done_i,
  input logic [31:0] least1_count_i,
  input logic [31:0] least2_count_i
);

  int unsigned fail_cnt = 0;

  // strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge hwclk) disable iff (reset)
    wb_stb_i |-> wb_cyc_i)
  else begin
    fail_cnt++;
    $error("wbs_stb_o high without wbs_cyc_o");
  end

  // strobe and address held until ack
  adr_held: assert property (@(posedge hwclk) disable iff (reset)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
  else begin
    fail_cnt++;
    $error("Wishbone cycle dropped or address moved before ack");
  end

  // no new character while the bus is busy
  ready_idle: assert property (@(posedge hwclk) disable iff (reset)
    char_ready_i |-> !wb_cyc_i)
  else begin
    fail_cnt++;
    $error("char_ready_o high during a Wishbone cycle");
  end

  reset_quiet: assert property (@(posedge hwclk)
    reset |-> !done_i && !char_ready_i)
  else begin
    fail_cnt++;
    $error("done_o or char_ready_o high during reset");
  end

  done_sticky: assert property (@(posedge hwclk) disable iff (reset)
    done_i |=> done_i)
  else begin
    fail_cnt++;
    $error("done_o fell before reset");
  end

  // a zero second count means only one character occurred
  least_order: assert property (@(posedge hwclk) disable iff (reset)
    done_i && (least2_count_i != 0) |-> least1_count_i <= least2_count_i)
  else begin
    fail_cnt++;
    $error("least1 count is greater than least2 count");
  end

endmodule

// ==== tests/huff_tb.sv ====
`timescale 1ns/1ps

module huff_tb
  import huff_pkg::*;
;

  localparam logic [31:0] base_addr  = 32'h0000_0400;
  localparam int          num_chars  = 40;
  localparam int          wait_limit = 4000;

  logic               hwclk;
  logic               reset;
  logic               char_valid_i;
  logic [char_w-1:0]  char_i;
  logic               char_ready_o;
  logic               done_o;
  logic [count_w-1:0] total_o;
  logic [char_w-1:0]  least1_char_o;
  logic [count_w-1:0] least1_count_o;
  logic [char_w-1:0]  least2_char_o;
  logic [count_w-1:0] least2_count_o;
  logic               wbs_stb_o;
  logic               wbs_cyc_o;
  logic               wbs_we_o;
  logic [3:0]         wbs_sel_o;
  logic [31:0]        wbs_adr_o;
  logic [31:0]        wbs_dat_o;
  logic               wbs_ack_i;
  logic [31:0]        wbs_dat_i;

  // SRAM model storage and reference counts
  logic [31:0]       mem [alphabet_n];
  int unsigned       ref_cnt [alphabet_n];
  int unsigned       ref_total = 0;
  int                errors = 0;
  int                seed = 32'habfad787;
  // few symbols, so equal counts show up
  logic [char_w-1:0] alphabet [6] = '{7'h00, 7'h05, 7'h1b, 7'h41, 7'h6c, 7'h7f};

  huff_top #(
    .base_addr(base_addr)
  ) u_dut (
    .hwclk         (hwclk),
    .reset         (reset),
    .char_valid_i  (char_valid_i),
    .char_i        (char_i),
    .char_ready_o  (char_ready_o),
    .done_o        (done_o),
    .total_o       (total_o),
    .least1_char_o (least1_char_o),
    .least1_count_o(least1_count_o),
    .least2_char_o (least2_char_o),
    .least2_count_o(least2_count_o),
    .wbs_stb_o     (wbs_stb_o),
    .wbs_cyc_o     (wbs_cyc_o),
    .wbs_we_o      (wbs_we_o),
    .wbs_sel_o     (wbs_sel_o),
    .wbs_adr_o     (wbs_adr_o),
    .wbs_dat_o     (wbs_dat_o),
    .wbs_ack_i     (wbs_ack_i),
    .wbs_dat_i     (wbs_dat_i)
  );

  bind huff_top huff_checker u_chk (
    .hwclk         (hwclk),
    .reset         (reset),
    .wb_stb_i      (wbs_stb_o),
    .wb_cyc_i      (wbs_cyc_o),
    .wb_adr_i      (wbs_adr_o),
    .wb_ack_i      (wbs_ack_i),
    .char_ready_i  (char_ready_o),
    .done_i        (done_o),
    .least1_count_i(least1_count_o),
    .least2_count_i(least2_count_o)
  );

  initial begin
    hwclk = 1'b0;
    forever #10 hwclk = ~hwclk;
  end

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (exp == act) else begin
      errors++;
      $display("Mismatch %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // hold the character until the DUT takes it
  task automatic send_char(input logic [char_w-1:0] c, input bit first, inout bit stalled);
    int cycles;
    int k;
    cycles = 0;
    char_valid_i = 1'b1;
    char_i = c;
    while (!char_ready_o && cycles < wait_limit) begin
      @(posedge hwclk);
      #2;
      cycles++;
    end
    if (!char_ready_o) begin
      errors++;
      stalled = 1'b1;
      $display("Timeout: char_ready_o stayed low for %0d cycles", wait_limit);
    end else begin
      // table must be wiped before the first character lands
      if (first) begin
        for (k = 0; k < alphabet_n; k++) begin
          compare_word($sformatf("clear[%0d]", k), 32'd0, mem[k]);
        end
      end
      @(posedge hwclk);
      #2;
    end
    char_valid_i = 1'b0;
  endtask

  task automatic wait_done(inout bit stalled);
    int cycles;
    cycles = 0;
    while (!done_o && cycles < wait_limit) begin
      @(posedge hwclk);
      #2;
      cycles++;
    end
    if (!done_o) begin
      errors++;
      stalled = 1'b1;
      $display("Timeout: done_o never rose after the end-of-file character");
    end
  endtask

  // Wishbone slave with 0 to 3 wait cycles
  initial begin : sram_model
    int wait_n;
    int idx;
    wbs_ack_i = 1'b0;
    wbs_dat_i = '0;
    for (idx = 0; idx < alphabet_n; idx++) begin
      mem[idx] = 32'hc3a5_0000 | (32'(idx) * 32'h0000_0101);
    end
    forever begin
      @(posedge hwclk);
      #2;
      wbs_ack_i = 1'b0;
      if (wbs_stb_o && wbs_cyc_o) begin
        wait_n = int'($unsigned($random(seed)) % 32'd4);
        repeat (wait_n) begin
          @(posedge hwclk);
          #2;
        end
        // every transfer is a full word
        compare_word("wbs_sel", 32'h0000_000f, 32'(wbs_sel_o));
        idx = int'((wbs_adr_o - base_addr) >> 2);
        assert (idx >= 0 && idx < alphabet_n) else begin
          errors++;
          $display("Wishbone address %0h lies outside the table", wbs_adr_o);
        end
        if (idx >= 0 && idx < alphabet_n) begin
          if (wbs_we_o) mem[idx] = wbs_dat_o;
          else wbs_dat_i = mem[idx];
        end
        wbs_ack_i = 1'b1;
      end
    end
  end

  initial begin : main_flow
    int n;
    int k;
    int best1;
    int best2;
    logic [char_w-1:0] ch;
    bit stalled;
    reset = 1'b1;
    char_valid_i = 1'b0;
    char_i = '0;
    stalled = 1'b0;
    for (k = 0; k < alphabet_n; k++) ref_cnt[k] = 0;
    repeat (10) @(posedge hwclk);
    #2;
    reset = 1'b0;

    for (n = 0; n <= num_chars && !stalled; n++) begin
      if (n == num_chars) begin
        ch = eof_char;
      end else begin
        ch = alphabet[int'($unsigned($random(seed)) % 32'd6)];
        ref_cnt[ch]++;
        ref_total++;
      end
      send_char(ch, n == 0, stalled);
    end
    if (!stalled) wait_done(stalled);

    if (!stalled) begin
      for (k = 0; k < alphabet_n; k++) begin
        compare_word($sformatf("count[%0d]", k), ref_cnt[k], mem[k]);
      end
      compare_word("total", ref_total, total_o);
      // smallest nonzero count, lower code on a tie
      best1 = -1;
      best2 = -1;
      for (k = 0; k < alphabet_n; k++) begin
        if (ref_cnt[k] != 0 && (best1 < 0 || ref_cnt[k] < ref_cnt[best1])) best1 = k;
      end
      for (k = 0; k < alphabet_n; k++) begin
        if (k != best1 && ref_cnt[k] != 0 && (best2 < 0 || ref_cnt[k] < ref_cnt[best2])) begin
          best2 = k;
        end
      end
      compare_word("least1_char", (best1 < 0) ? 32'd0 : 32'(best1), 32'(least1_char_o));
      compare_word("least1_count", (best1 < 0) ? 32'd0 : ref_cnt[best1], least1_count_o);
      compare_word("least2_char", (best2 < 0) ? 32'd0 : 32'(best2), 32'(least2_char_o));
      compare_word("least2_count", (best2 < 0) ? 32'd0 : ref_cnt[best2], least2_count_o);
    end

    $display("error count: %0d testbench, %0d assertion", errors, u_dut.u_chk.fail_cnt);
    if (errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
